// File: hdl/cart_config.svh
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

// External PRG memory address width
`define ADDR_BITS 18

// Launcher owns the top 32 KB, work RAM sits 8 KB below it
`define LAUNCHER_BASE ({`ADDR_BITS{1'b1}} << 15)
`define WRAM_BASE (`LAUNCHER_BASE - `ADDR_BITS'(16'h2000))

// Host register map
`define REG_MAPPER 4'd0
`define REG_LAUNCHER 4'd1

// Low bytes of the 6502 vectors
`define VEC_RESET 16'hFFFC
`define VEC_NMI 16'hFFFA

`endif

// File: hdl/cart_pkg.sv
`include "cart_config.svh"

package cart_pkg;

    typedef enum logic [1:0] {
        MAP_LAUNCHER,
        MAP_NROM,
        MAP_UXROM,
        MAP_CNROM
    } map_id_t;

    typedef enum logic [2:0] {
        IDLE,
        MEM_READ,
        CONFLICT_READ,
        REG_WRITE,
        OPEN_BUS,
        DONE
    } mux_state_t;

    // rw high is a read
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        rw;
    } cpu_bus_t;

    typedef struct packed {
        map_id_t               game;
        logic [`ADDR_BITS-1:0] prg_mask;
        logic [`ADDR_BITS-1:0] chr_mask;
        logic                  mirroring;
        logic                  bus_conflict;
    } map_cfg_t;

    typedef struct packed {
        logic [`ADDR_BITS-1:0] addr;
        logic [7:0]            wdata;
        logic                  we;
    } mem_req_t;

    typedef struct packed {
        logic [`ADDR_BITS-1:0] prg_addr;
        logic [`ADDR_BITS-1:0] chr_addr;
        logic                  ciram_a10;
    } map_out_t;

endpackage

// File: hdl/map_regs.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module map_regs import cart_pkg::*; (
    input  logic        clk,
    input  logic        cpu_reset,
    input  logic [15:0] wr_reg,
    input  logic [3:0]  wr_reg_addr,
    input  logic        wr_reg_valid,
    input  logic        cpu_req,
    input  cpu_bus_t    cpu_bus,
    output map_cfg_t    cfg,
    output map_id_t     active
);
    logic                  start_app;
    logic                  ingame_menu;
    map_id_t               select_reg;
    logic                  reset_hijack;
    logic                  nmi_hijack;
    logic [4:0]            size_exp;
    logic [`ADDR_BITS-1:0] size_mask;

    // Vector fetch seen while the CPU request is open
    assign reset_hijack = start_app && cpu_req && cpu_bus.rw && cpu_bus.addr == `VEC_RESET;
    assign nmi_hijack = ingame_menu && cpu_req && cpu_bus.rw && cpu_bus.addr == `VEC_NMI;

    // Vector byte itself must come from the new mapper
    assign active = reset_hijack ? cfg.game : (nmi_hijack ? MAP_LAUNCHER : select_reg);

    // 2^e - 1, saturating at the full address range
    assign size_exp = wr_reg[6:2];
    assign size_mask = ~({`ADDR_BITS{1'b1}} << size_exp);

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            cfg <= '0;
            start_app <= 1'b0;
            ingame_menu <= 1'b0;
            select_reg <= MAP_LAUNCHER;
        end else begin
            if (wr_reg_valid && wr_reg_addr == `REG_MAPPER) begin
                cfg.game <= map_id_t'(wr_reg[1:0]);
                cfg.prg_mask <= size_mask;
                cfg.chr_mask <= size_mask >> 1;
                cfg.mirroring <= wr_reg[8];
                cfg.bus_conflict <= wr_reg[9];
            end
            if (wr_reg_valid && wr_reg_addr == `REG_LAUNCHER) begin
                start_app <= wr_reg[0];
                ingame_menu <= wr_reg[1];
            end

            // Launch the game
            if (reset_hijack) begin
                select_reg <= cfg.game;
                start_app <= 1'b0;
            end

            // Back to the menu
            if (nmi_hijack) begin
                select_reg <= MAP_LAUNCHER;
                ingame_menu <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/mapper_uxrom.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module mapper_uxrom import cart_pkg::*; (
    input  logic        clk,
    input  logic        cpu_reset,
    input  cpu_bus_t    cpu_bus,
    input  logic        bank_we,
    input  logic [7:0]  bank_data,
    input  logic [13:0] ppu_addr,
    input  logic        mirroring,
    output map_out_t    out
);
    logic [3:0] prg_bank;

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            prg_bank <= '0;
        end else if (bank_we) begin
            prg_bank <= bank_data[3:0];
        end
    end

    always_comb begin
        // C000-FFFF fixed to the last bank, the size mask trims the ones
        if (cpu_bus.addr[14]) begin
            out.prg_addr = {{(`ADDR_BITS-14){1'b1}}, cpu_bus.addr[13:0]};
        end else begin
            out.prg_addr = `ADDR_BITS'({prg_bank, cpu_bus.addr[13:0]});
        end
        // CHR is a fixed 8 KB
        out.chr_addr = `ADDR_BITS'(ppu_addr[12:0]);
        out.ciram_a10 = mirroring ? ppu_addr[10] : ppu_addr[11];
    end

endmodule

// File: hdl/mapper_cnrom.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module mapper_cnrom import cart_pkg::*; (
    input  logic        clk,
    input  logic        cpu_reset,
    input  cpu_bus_t    cpu_bus,
    input  logic        bank_we,
    input  logic [7:0]  bank_data,
    input  logic [13:0] ppu_addr,
    input  logic        mirroring,
    output map_out_t    out
);
    logic [1:0] chr_bank;

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            chr_bank <= '0;
        end else if (bank_we) begin
            chr_bank <= bank_data[1:0];
        end
    end

    always_comb begin
        // PRG flat, 16 KB images mirror through the size mask
        out.prg_addr = `ADDR_BITS'(cpu_bus.addr[14:0]);

        // Whole 8 KB pattern table window per bank
        out.chr_addr = `ADDR_BITS'({chr_bank, ppu_addr[12:0]});

        out.ciram_a10 = mirroring ? ppu_addr[10] : ppu_addr[11];
    end

endmodule

// File: hdl/mapper_mux.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module mapper_mux import cart_pkg::*; (
    input  logic                  clk,
    input  logic                  cpu_reset,
    input  logic                  cpu_req,
    input  cpu_bus_t              cpu_bus,
    input  map_cfg_t              cfg,
    input  map_id_t               active,
    input  logic [13:0]           ppu_addr,
    input  logic                  port_done,
    input  logic [7:0]            port_rdata,
    output logic                  cpu_ack,
    output logic [7:0]            cpu_rdata,
    output logic                  port_start,
    output mem_req_t              port_req,
    output logic [`ADDR_BITS-1:0] chr_addr,
    output logic                  ciram_a10
);
    mux_state_t            state;
    map_out_t              launcher_out, nrom_out, uxrom_out, cnrom_out, sel;
    logic                  mirror_a10;
    logic                  is_wram, is_open, is_prg_write, conflict;
    logic                  bank_we;
    logic [7:0]            bank_data;
    logic [`ADDR_BITS-1:0] prg_addr;

    assign mirror_a10 = cfg.mirroring ? ppu_addr[10] : ppu_addr[11];

    always_comb begin
        launcher_out.prg_addr = `LAUNCHER_BASE + `ADDR_BITS'(cpu_bus.addr[14:0]);
        launcher_out.chr_addr = `ADDR_BITS'(ppu_addr[12:0]);
        launcher_out.ciram_a10 = mirror_a10;
        nrom_out.prg_addr = `ADDR_BITS'(cpu_bus.addr[14:0]);
        nrom_out.chr_addr = `ADDR_BITS'(ppu_addr[12:0]);
        nrom_out.ciram_a10 = mirror_a10;
    end

    assign bank_we = (state == REG_WRITE);
    assign bank_data = conflict ? (cpu_bus.wdata & port_rdata) : cpu_bus.wdata;

    mapper_uxrom uxrom_inst (
        .clk(clk),
        .cpu_reset(cpu_reset),
        .cpu_bus(cpu_bus),
        .bank_we(bank_we && active == MAP_UXROM),
        .bank_data(bank_data),
        .ppu_addr(ppu_addr),
        .mirroring(cfg.mirroring),
        .out(uxrom_out)
    );

    mapper_cnrom cnrom_inst (
        .clk(clk),
        .cpu_reset(cpu_reset),
        .cpu_bus(cpu_bus),
        .bank_we(bank_we && active == MAP_CNROM),
        .bank_data(bank_data),
        .ppu_addr(ppu_addr),
        .mirroring(cfg.mirroring),
        .out(cnrom_out)
    );

    always_comb begin
        case (active)
            MAP_LAUNCHER: sel = launcher_out;
            MAP_NROM:     sel = nrom_out;
            MAP_UXROM:    sel = uxrom_out;
            default:      sel = cnrom_out;
        endcase
    end

    // CPU address decode
    assign is_wram = cpu_bus.addr[15:13] == 3'b011;
    assign is_open = !cpu_bus.addr[15] && !is_wram;
    assign is_prg_write = cpu_bus.addr[15] && !cpu_bus.rw;
    assign conflict = is_prg_write && cfg.bus_conflict && active != MAP_LAUNCHER;

    // Launcher region is fixed, games are trimmed to their ROM size
    always_comb begin
        if (is_wram) begin
            prg_addr = `WRAM_BASE + `ADDR_BITS'(cpu_bus.addr[12:0]);
        end else if (active == MAP_LAUNCHER) begin
            prg_addr = sel.prg_addr;
        end else begin
            prg_addr = sel.prg_addr & cfg.prg_mask;
        end
    end

    assign port_req = '{addr: prg_addr, wdata: cpu_bus.wdata, we: is_wram && !cpu_bus.rw};
    assign port_start = state == IDLE && cpu_req && !is_open && (conflict || !is_prg_write);

    // WRAM writes also pass through MEM_READ
    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (cpu_req) begin
                        if (is_open)
                            state <= OPEN_BUS;
                        else if (conflict)
                            state <= CONFLICT_READ;
                        else if (is_prg_write)
                            state <= REG_WRITE;
                        else
                            state <= MEM_READ;
                    end
                end
                MEM_READ: begin
                    if (port_done)
                        state <= DONE;
                end
                CONFLICT_READ: begin
                    if (port_done)
                        state <= REG_WRITE;
                end
                REG_WRITE, OPEN_BUS: state <= DONE;
                DONE: begin
                    if (!cpu_req)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign cpu_ack = (state == DONE);
    // Open bus returns the high address byte
    assign cpu_rdata = is_open ? cpu_bus.addr[15:8] : port_rdata;
    assign chr_addr = sel.chr_addr & cfg.chr_mask;
    assign ciram_a10 = sel.ciram_a10;

endmodule

// File: hdl/prg_port.sv
`timescale 1ns/1ps

module prg_port import cart_pkg::*; (
    input  logic       clk,
    input  logic       cpu_reset,
    input  logic       start,
    input  mem_req_t   req_in,
    input  logic       mem_ack,
    input  logic [7:0] mem_rdata,
    output logic       done,
    output logic [7:0] rdata,
    output logic       mem_req,
    output mem_req_t   mem
);
    // Waiting for the memory to drop its ack
    logic rtz;
    logic idle;

    assign idle = !mem_req && !rtz;

    always_ff @(posedge clk) begin
        if (cpu_reset) begin
            mem_req <= 1'b0;
            rtz <= 1'b0;
        end else if (mem_req) begin
            if (mem_ack) begin
                mem_req <= 1'b0;
                rtz <= 1'b1;
            end
        end else if (rtz) begin
            if (!mem_ack)
                rtz <= 1'b0;
        end else if (start) begin
            mem_req <= 1'b1;
        end
    end

    // Request stays frozen for the whole cycle
    always_ff @(posedge clk) begin
        if (start && idle)
            mem <= req_in;
        if (mem_req && mem_ack)
            rdata <= mem_rdata;
    end

    // Four-phase cycle complete
    assign done = rtz && !mem_ack;

endmodule

// File: hdl/cart_top.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module cart_top import cart_pkg::*; (
    input  logic                  clk,
    input  logic                  cpu_reset,
    input  logic [15:0]           wr_reg,
    input  logic [3:0]            wr_reg_addr,
    input  logic                  wr_reg_valid,
    input  logic                  cpu_req,
    input  cpu_bus_t              cpu_bus,
    input  logic [13:0]           ppu_addr,
    input  logic                  mem_ack,
    input  logic [7:0]            mem_rdata,
    output logic                  cpu_ack,
    output logic [7:0]            cpu_rdata,
    output logic [`ADDR_BITS-1:0] chr_addr,
    output logic                  ciram_a10,
    output logic                  mem_req,
    output mem_req_t              mem
);
    map_cfg_t   cfg;
    map_id_t    active;
    logic       port_start;
    mem_req_t   port_req;
    logic       port_done;
    logic [7:0] port_rdata;

    map_regs map_regs_inst (
        .clk(clk),
        .cpu_reset(cpu_reset),
        .wr_reg(wr_reg),
        .wr_reg_addr(wr_reg_addr),
        .wr_reg_valid(wr_reg_valid),
        .cpu_req(cpu_req),
        .cpu_bus(cpu_bus),
        .cfg(cfg),
        .active(active)
    );

    mapper_mux mapper_mux_inst (
        .clk(clk),
        .cpu_reset(cpu_reset),
        .cpu_req(cpu_req),
        .cpu_bus(cpu_bus),
        .cfg(cfg),
        .active(active),
        .ppu_addr(ppu_addr),
        .port_done(port_done),
        .port_rdata(port_rdata),
        .cpu_ack(cpu_ack),
        .cpu_rdata(cpu_rdata),
        .port_start(port_start),
        .port_req(port_req),
        .chr_addr(chr_addr),
        .ciram_a10(ciram_a10)
    );

    prg_port prg_port_inst (
        .clk(clk),
        .cpu_reset(cpu_reset),
        .start(port_start),
        .req_in(port_req),
        .mem_ack(mem_ack),
        .mem_rdata(mem_rdata),
        .done(port_done),
        .rdata(port_rdata),
        .mem_req(mem_req),
        .mem(mem)
    );

endmodule

// File: sim/cart_checker.sv
`timescale 1ns/1ps

module cart_checker import cart_pkg::*; (
    input logic     clk,
    input logic     cpu_reset,
    input logic     cpu_req,
    input logic     cpu_ack,
    input logic     mem_req,
    input logic     mem_ack,
    input mem_req_t mem
);
    // CPU keeps its request open until the ack
    assert property (@(posedge clk) disable iff (cpu_reset)
        cpu_req && !cpu_ack |=> cpu_req)
        else $error("cpu_req dropped before cpu_ack");

    assert property (@(posedge clk) disable iff (cpu_reset)
        mem_req && $past(mem_req) |-> $stable(mem))
        else $error("mem changed while mem_req was high");

    // Memory must return to zero first
    assert property (@(posedge clk) disable iff (cpu_reset)
        !mem_req && mem_ack |=> !mem_req)
        else $error("mem_req rose while mem_ack was high");

    assert property (@(posedge clk) cpu_reset |=> !cpu_ack && !mem_req)
        else $error("cpu_ack or mem_req high during reset");

endmodule

bind cart_top cart_checker cart_checker_inst (
    .clk(clk),
    .cpu_reset(cpu_reset),
    .cpu_req(cpu_req),
    .cpu_ack(cpu_ack),
    .mem_req(mem_req),
    .mem_ack(mem_ack),
    .mem(mem)
);

// File: sim/tb_cart.sv
`timescale 1ns/1ps
`include "cart_config.svh"

module tb_cart import cart_pkg::*; ();

    localparam int MEM_SIZE = 2 ** `ADDR_BITS;
    localparam int NUM_TESTS = 6;
    localparam int ACCESS_BUDGET = 16;
    localparam int WATCHDOG_CYCLES = 200 * ACCESS_BUDGET * NUM_TESTS;
    localparam int ACK_LIMIT = 100;

    logic                  clk;
    logic                  cpu_reset;
    logic [15:0]           wr_reg;
    logic [3:0]            wr_reg_addr;
    logic                  wr_reg_valid;
    logic                  cpu_req;
    cpu_bus_t              cpu_bus;
    logic [13:0]           ppu_addr;
    logic                  mem_ack;
    logic [7:0]            mem_rdata;
    logic                  cpu_ack;
    logic [7:0]            cpu_rdata;
    logic [`ADDR_BITS-1:0] chr_addr;
    logic                  ciram_a10;
    logic                  mem_req;
    mem_req_t              mem;

    logic [7:0]            prg_mem [0:MEM_SIZE-1];
    logic [`ADDR_BITS-1:0] last_addr;
    logic                  last_we;
    logic [31:0]           lfsr = 32'h459c;
    int                    errors = 0;
    int                    checks = 0;

    // Expected mapper state, tracked from the register and bank writes
    map_id_t               exp_map = MAP_LAUNCHER;
    logic [3:0]            ux_bank = '0;
    logic [1:0]            cn_bank = '0;
    logic [`ADDR_BITS-1:0] prg_mask = '0;
    logic [`ADDR_BITS-1:0] chr_mask = '0;
    logic                  exp_mirror = 1'b0;

    cart_top cart_top_inst (
        .clk(clk),
        .cpu_reset(cpu_reset),
        .wr_reg(wr_reg),
        .wr_reg_addr(wr_reg_addr),
        .wr_reg_valid(wr_reg_valid),
        .cpu_req(cpu_req),
        .cpu_bus(cpu_bus),
        .ppu_addr(ppu_addr),
        .mem_ack(mem_ack),
        .mem_rdata(mem_rdata),
        .cpu_ack(cpu_ack),
        .cpu_rdata(cpu_rdata),
        .chr_addr(chr_addr),
        .ciram_a10(ciram_a10),
        .mem_req(mem_req),
        .mem(mem)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // All address bytes folded, so banks and regions read differently
    function automatic logic [7:0] fill_byte(input logic [`ADDR_BITS-1:0] a);
        logic [`ADDR_BITS+7:0] wide;
        logic [7:0]            acc;
        wide = {8'h00, a};
        acc = 8'h00;
        for (int i = 0; i < `ADDR_BITS; i += 8)
            acc = acc ^ wide[i +: 8];
        return acc;
    endfunction

    function automatic logic [`ADDR_BITS-1:0] expected_prg(input logic [15:0] a);
        logic [`ADDR_BITS-1:0] low15;
        logic [`ADDR_BITS-1:0] last_bank;
        low15 = `ADDR_BITS'(a[14:0]);
        last_bank = prg_mask & {{(`ADDR_BITS-14){1'b1}}, 14'h0000};
        case (exp_map)
            MAP_LAUNCHER: return `LAUNCHER_BASE + low15;
            MAP_UXROM: return a[14] ? (last_bank | `ADDR_BITS'(a[13:0]))
                                    : (`ADDR_BITS'({ux_bank, a[13:0]}) & prg_mask);
            default: return low15 & prg_mask;
        endcase
    endfunction

    task automatic next_ack_delay(output int cycles);
        logic [1:0] bits;
        lfsr = lfsr_step(lfsr);
        bits[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        bits[1] = lfsr[0];
        cycles = 1 + int'(bits);
    endtask

    // PRG memory with a random ack delay of 1 to 4 cycles
    initial begin
        int ack_wait;
        mem_ack <= 1'b0;
        mem_rdata <= 8'h00;
        for (int a = 0; a < MEM_SIZE; a++)
            prg_mem[a] = fill_byte(`ADDR_BITS'(a));
        forever begin
            @(posedge clk);
            if (mem_req && !mem_ack) begin
                next_ack_delay(ack_wait);
                repeat (ack_wait - 1) @(posedge clk);
                last_addr = mem.addr;
                last_we = mem.we;
                if (mem.we)
                    prg_mem[mem.addr] = mem.wdata;
                mem_rdata <= prg_mem[mem.addr];
                mem_ack <= 1'b1;
                do begin
                    @(posedge clk);
                end while (mem_req);
                mem_ack <= 1'b0;
            end
        end
    end

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [`ADDR_BITS-1:0] got,
                              input logic [`ADDR_BITS-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic host_write(input logic [3:0] reg_addr, input logic [15:0] value);
        @(posedge clk);
        wr_reg <= value;
        wr_reg_addr <= reg_addr;
        wr_reg_valid <= 1'b1;
        @(posedge clk);
        wr_reg_valid <= 1'b0;
    endtask

    task automatic set_mapper(input map_id_t game, input logic [4:0] size_exp,
                              input logic mirror, input logic conflict);
        host_write(`REG_MAPPER, {6'b0, conflict, mirror, 1'b0, size_exp, game});
        prg_mask = (`ADDR_BITS'(1) << size_exp) - `ADDR_BITS'(1);
        chr_mask = (`ADDR_BITS'(1) << (size_exp - 5'd1)) - `ADDR_BITS'(1);
        exp_mirror = mirror;
    endtask

    task automatic cpu_access(input logic [15:0] cpu_addr, input logic [7:0] wdata,
                              input logic rw, output logic [7:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        cpu_bus <= '{addr: cpu_addr, wdata: wdata, rw: rw};
        cpu_req <= 1'b1;
        do begin
            @(posedge clk);
            waited++;
        end while (!cpu_ack && waited < ACK_LIMIT);
        rdata = cpu_rdata;
        if (!cpu_ack) begin
            errors++;
            $display("No cpu_ack for the access at %h", cpu_addr);
        end
        cpu_req <= 1'b0;
        waited = 0;
        while (cpu_ack && waited < ACK_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (cpu_ack) begin
            errors++;
            $display("cpu_ack stayed high after the access at %h", cpu_addr);
        end
    endtask

    task automatic cpu_write(input logic [15:0] cpu_addr, input logic [7:0] wdata);
        logic [7:0] unused;
        cpu_access(cpu_addr, wdata, 1'b0, unused);
    endtask

    task automatic read_check(input logic [15:0] cpu_addr);
        logic [7:0]            got;
        logic [7:0]            exp;
        logic [`ADDR_BITS-1:0] exp_addr;
        logic                  is_mem;
        is_mem = cpu_addr >= 16'h6000;
        if (cpu_addr[15])
            exp_addr = expected_prg(cpu_addr);
        else
            exp_addr = `WRAM_BASE + `ADDR_BITS'(cpu_addr[12:0]);
        // Open bus floats the high address byte
        exp = is_mem ? prg_mem[exp_addr] : cpu_addr[15:8];
        cpu_access(cpu_addr, 8'h00, 1'b1, got);
        check_byte($sformatf("cpu_rdata[%h]", cpu_addr), got, exp);
        if (is_mem)
            check_addr($sformatf("mem.addr[%h]", cpu_addr), last_addr, exp_addr);
    endtask

    task automatic cnrom_chr_check(input logic [13:0] ppu);
        logic [`ADDR_BITS-1:0] exp_chr;
        exp_chr = `ADDR_BITS'({cn_bank, ppu[12:0]}) & chr_mask;
        @(posedge clk);
        ppu_addr <= ppu;
        @(posedge clk);
        check_addr($sformatf("chr_addr[%h]", ppu), chr_addr, exp_chr);
        check_bit($sformatf("ciram_a10[%h]", ppu), ciram_a10, exp_mirror ? ppu[10] : ppu[11]);
    endtask

    task automatic test_reset_launcher();
        read_check(16'h8000);
        read_check(16'hC123);
        read_check(`VEC_RESET);
        read_check(16'h4017);
        read_check(16'h0000);
    endtask

    task automatic test_game_start();
        set_mapper(MAP_UXROM, 5'd17, 1'b0, 1'b0);
        host_write(`REG_LAUNCHER, 16'h0001);
        // Vector byte itself comes from the game
        exp_map = MAP_UXROM;
        read_check(`VEC_RESET);
        read_check(16'h8010);
        read_check(16'hE000);
        // start_app is spent, a new game id must not take over
        set_mapper(MAP_CNROM, 5'd17, 1'b0, 1'b0);
        read_check(`VEC_RESET);
        set_mapper(MAP_UXROM, 5'd17, 1'b0, 1'b0);
    endtask

    task automatic test_uxrom_banking();
        logic [7:0] rom;
        logic [7:0] merged;
        cpu_write(16'hC000, 8'h03);
        ux_bank = 4'h3;
        read_check(16'h8000);
        read_check(16'hB456);
        read_check(16'hC000);
        set_mapper(MAP_UXROM, 5'd17, 1'b0, 1'b1);
        rom = prg_mem[expected_prg(16'hC005)];
        cpu_write(16'hC005, 8'hFF);
        // Bus conflict, ROM drives against the CPU
        merged = rom & 8'hFF;
        ux_bank = merged[3:0];
        check_addr("mem.addr[c005]", last_addr, expected_prg(16'hC005));
        check_bit("mem.we[c005]", last_we, 1'b0);
        read_check(16'h8000);
        read_check(16'h9ABC);
        read_check(16'hFFFF);
    endtask

    task automatic test_cnrom_chr();
        set_mapper(MAP_CNROM, 5'd16, 1'b0, 1'b0);
        host_write(`REG_LAUNCHER, 16'h0001);
        exp_map = MAP_CNROM;
        read_check(`VEC_RESET);
        cpu_write(16'h8000, 8'h02);
        cn_bank = 2'd2;
        read_check(16'hC000);
        for (int m = 0; m < 2; m++) begin
            set_mapper(MAP_CNROM, 5'd16, m[0], 1'b0);
            cnrom_chr_check(14'h0123);
            cnrom_chr_check(14'h1ABC);
            cnrom_chr_check(14'h2800);
            cnrom_chr_check(14'h2400);
        end
    endtask

    task automatic test_wram();
        cpu_write(16'h6123, 8'h5A);
        check_addr("mem.addr[6123]", last_addr, `WRAM_BASE + `ADDR_BITS'(13'h0123));
        check_bit("mem.we[6123]", last_we, 1'b1);
        check_byte("wram[0123]", prg_mem[`WRAM_BASE + `ADDR_BITS'(13'h0123)], 8'h5A);
        cpu_write(16'h7FFF, 8'hA5);
        check_byte("wram[1fff]", prg_mem[`WRAM_BASE + `ADDR_BITS'(13'h1FFF)], 8'hA5);
        read_check(16'h6123);
        read_check(16'h7FFF);
    endtask

    task automatic test_ingame_menu();
        host_write(`REG_LAUNCHER, 16'h0002);
        exp_map = MAP_LAUNCHER;
        read_check(`VEC_NMI);
        read_check(16'h8000);
        read_check(`VEC_NMI);
        read_check(16'hC5A5);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

    initial begin
        cpu_reset <= 1'b1;
        wr_reg <= '0;
        wr_reg_addr <= '0;
        wr_reg_valid <= 1'b0;
        cpu_req <= 1'b0;
        cpu_bus <= '0;
        ppu_addr <= '0;
        repeat (10) @(posedge clk);
        cpu_reset <= 1'b0;
        test_reset_launcher();
        test_game_start();
        test_uxrom_banking();
        test_cnrom_chr();
        test_wram();
        test_ingame_menu();
        @(posedge clk);
        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: tb.f
+incdir+hdl
hdl/cart_pkg.sv
hdl/map_regs.sv
hdl/mapper_uxrom.sv
hdl/mapper_cnrom.sv
hdl/mapper_mux.sv
hdl/prg_port.sv
hdl/cart_top.sv
sim/cart_checker.sv
sim/tb_cart.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build tb_cart with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --assert -f tb.f --top-module tb_cart -Mdir obj_dir
	./obj_dir/Vtb_cart | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
